// File: list.f
+incdir+tests
rtl/id_queue_cfg_pkg.sv
rtl/id_queue_types_pkg.sv
rtl/first_free_index.sv
rtl/head_tail_store.sv
rtl/linked_data_store.sv
rtl/id_queue_push.sv
rtl/id_queue_pop.sv
rtl/id_queue_top.sv
tests/tb_id_queue.sv

// File: run.sh
#!/bin/sh
# Builds the ID queue testbench with Verilator and runs it
# The run counts as passed only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_id_queue -f list.f -o sim_tb_id_queue
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_id_queue)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^SIMULATION PASSED$"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// File: tests/tb_id_queue_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the ID queue
// All stored elements in push order with their IDs
// Reference functions for push, pop, peek and exists
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_ID_QUEUE_MODEL_SVH
`define TB_ID_QUEUE_MODEL_SVH

// Both queues grow together, so entry i of one belongs to entry i of the other
id_t   model_ids[$];
data_t model_data[$];

function automatic void model_push(input id_t id, input data_t data);
    model_ids.push_back(id);
    model_data.push_back(data);
endfunction

// Position of the oldest element of an ID, or -1 when the ID holds nothing
function automatic int model_find(input id_t id);
    int pos;
    pos = -1;
    for (int i = model_ids.size() - 1; i >= 0; i--) begin
        if (model_ids[i] == id) begin
            pos = i;
        end
    end
    return pos;
endfunction

// Returns whether the ID has an element and hands out its oldest payload
function automatic logic model_peek(input id_t id, output data_t data);
    int pos;
    pos  = model_find(id);
    data = '0;
    if (pos >= 0) begin
        data = model_data[pos];
    end
    return (pos >= 0);
endfunction

function automatic void model_pop(input id_t id);
    int pos;
    pos = model_find(id);
    if (pos >= 0) begin
        model_ids.delete(pos);
        model_data.delete(pos);
    end
endfunction

// A stored payload matches when it agrees with the query on every masked bit
function automatic logic model_exists(input data_t data, input data_t mask);
    logic found;
    found = 1'b0;
    for (int i = 0; i < model_data.size(); i++) begin
        if (((model_data[i] ^ data) & mask) == '0) begin
            found = 1'b1;
        end
    end
    return found;
endfunction

function automatic int model_count();
    return model_ids.size();
endfunction

function automatic int model_count_id(input id_t id);
    int n;
    n = 0;
    for (int i = 0; i < model_ids.size(); i++) begin
        if (model_ids[i] == id) begin
            n++;
        end
    end
    return n;
endfunction

`endif

// File: tests/tb_id_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the ID queue
// Clock, reset and stimulus for the input, output and exists ports
// Compare process against the reference model, check task, summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_id_queue;

    import id_queue_cfg_pkg::*;
    import id_queue_types_pkg::*;

    localparam int ClkPeriod   = 100;
    localparam int StimDelay   = 10;
    localparam int ResetCycles = 16;
    localparam int WaitLimit   = 50;
    localparam int RandomOps   = 300;
    localparam int RandSeed    = 32'he6a2_37d0;

    logic  clk_i;
    logic  rst_ni;
    logic  inp_req_i;
    id_t   inp_id_i;
    data_t inp_data_i;
    logic  inp_gnt_o;
    logic  oup_req_i;
    id_t   oup_id_i;
    logic  oup_pop_i;
    logic  oup_gnt_o;
    logic  oup_data_valid_o;
    data_t oup_data_o;
    logic  exists_req_i;
    data_t exists_data_i;
    data_t exists_mask_i;
    logic  exists_gnt_o;
    logic  exists_o;
    logic  full_o;
    logic  empty_o;

    int    checks;
    int    errors;
    string test_name;

    `include "tb_id_queue_model.svh"

    id_queue_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever begin
            #(ClkPeriod / 2);
            clk_i = ~clk_i;
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR [%s] %s: expected 0x%0h, actual 0x%0h at %0t",
                     test_name, what, expected, actual, $time);
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // Polls one grant at the falling edge, where the combinational outputs have settled
    task automatic wait_grant(input logic output_side, input string what);
        int   cycles;
        logic granted;
        cycles = 0;
        @(negedge clk_i);
        granted = output_side ? oup_gnt_o : inp_gnt_o;
        while (!granted && cycles < WaitLimit) begin
            cycles++;
            @(negedge clk_i);
            granted = output_side ? oup_gnt_o : inp_gnt_o;
        end
        if (!granted) begin
            $display("Timeout: no %s within %0d cycles in test %s", what, WaitLimit,
                     test_name);
            errors++;
            finish_run();
        end
    endtask

    // Every stimulus task starts and ends a short delay after a rising edge
    task automatic push_elem(input id_t id, input data_t data);
        inp_req_i  = 1'b1;
        inp_id_i   = id;
        inp_data_i = data;
        wait_grant(1'b0, "input grant");
        @(posedge clk_i);
        #StimDelay;
        inp_req_i = 1'b0;
    endtask

    task automatic access_elem(input id_t id, input logic pop);
        oup_req_i = 1'b1;
        oup_id_i  = id;
        oup_pop_i = pop;
        wait_grant(1'b1, "output grant");
        @(posedge clk_i);
        #StimDelay;
        oup_req_i = 1'b0;
        oup_pop_i = 1'b0;
    endtask

    task automatic drain_all();
        for (int i = 0; i < NumIds; i++) begin
            while (model_count_id(id_t'(i)) > 0) begin
                access_elem(id_t'(i), 1'b1);
            end
        end
    endtask

    // Expected outputs come from the model state as it stands before the coming edge
    always @(negedge clk_i) begin : compare_outputs
        logic  exp_inp_gnt;
        logic  exp_push;
        logic  exp_oup_gnt;
        logic  exp_valid;
        logic  peek_hit;
        data_t peek_data;
        logic  exp_exists;
        if (rst_ni) begin
            exp_inp_gnt = (model_count() < Capacity);
            exp_push    = inp_req_i && exp_inp_gnt;
            exp_oup_gnt = oup_req_i && !exp_push;
            peek_hit    = model_peek(oup_id_i, peek_data);
            exp_valid   = exp_oup_gnt && peek_hit;
            exp_exists  = exists_req_i && model_exists(exists_data_i, exists_mask_i);
            check("inp_gnt_o", 32'(exp_inp_gnt), 32'(inp_gnt_o));
            check("full_o", 32'(model_count() == Capacity), 32'(full_o));
            check("empty_o", 32'(model_count() == 0), 32'(empty_o));
            check("oup_gnt_o", 32'(exp_oup_gnt), 32'(oup_gnt_o));
            check("oup_data_valid_o", 32'(exp_valid), 32'(oup_data_valid_o));
            check("oup_data_o", 32'(exp_valid ? peek_data : '0), 32'(oup_data_o));
            check("exists_gnt_o", 32'(exists_req_i), 32'(exists_gnt_o));
            check("exists_o", 32'(exp_exists), 32'(exists_o));
            // Mirror the state change that the DUT performs at the next rising edge
            if (exp_push) begin
                model_push(inp_id_i, inp_data_i);
            end else if (exp_valid && oup_pop_i) begin
                model_pop(oup_id_i);
            end
        end
    end

    initial begin
        int op;
        void'($urandom(RandSeed));
        checks        = 0;
        errors        = 0;
        test_name     = "reset";
        rst_ni        = 1'b0;
        inp_req_i     = 1'b0;
        inp_id_i      = '0;
        inp_data_i    = '0;
        oup_req_i     = 1'b0;
        oup_id_i      = '0;
        oup_pop_i     = 1'b0;
        exists_req_i  = 1'b0;
        exists_data_i = '0;
        exists_mask_i = '0;
        repeat (ResetCycles) @(posedge clk_i);
        #StimDelay;
        rst_ni = 1'b1;

        // Every ID is empty right after reset, so each peek is granted without data
        test_name = "after_reset";
        for (int i = 0; i < NumIds; i++) begin
            access_elem(id_t'(i), 1'b0);
        end

        // Mixed pushes, peeks and pops with sparse exists masks alongside
        test_name = "random_traffic";
        repeat (RandomOps) begin
            exists_req_i  = 1'($urandom_range(1, 0));
            exists_data_i = data_t'($urandom);
            exists_mask_i = data_t'($urandom & $urandom & $urandom);
            op = int'($urandom_range(3, 0));
            if (op < 2 && model_count() < Capacity) begin
                push_elem(id_t'($urandom_range(NumIds - 1, 0)), data_t'($urandom));
            end else begin
                access_elem(id_t'($urandom_range(NumIds - 1, 0)), op != 3);
            end
        end
        exists_req_i = 1'b0;

        // Fill every cell, then hold a push that only gets through after one pop
        test_name = "full";
        drain_all();
        for (int i = 0; i < Capacity; i++) begin
            push_elem(id_t'(i % NumIds), data_t'($urandom));
        end
        inp_req_i  = 1'b1;
        inp_id_i   = id_t'(2);
        inp_data_i = data_t'($urandom);
        @(negedge clk_i);
        check("full_o while full", 32'd1, 32'(full_o));
        check("inp_gnt_o while full", 32'd0, 32'(inp_gnt_o));
        @(posedge clk_i);
        #StimDelay;
        access_elem(id_t'(0), 1'b1);
        wait_grant(1'b0, "input grant after pop");
        @(posedge clk_i);
        #StimDelay;
        inp_req_i = 1'b0;

        // Queries taken from stored payloads must hit while random ones may or may not
        test_name = "exists";
        for (int i = 0; i < 40; i++) begin
            exists_req_i  = 1'b1;
            exists_mask_i = (i == 0) ? '0 : data_t'($urandom);
            if (i % 2 == 0) begin
                exists_data_i = model_data[$urandom_range(model_count() - 1, 0)];
            end else begin
                exists_data_i = data_t'($urandom);
            end
            @(posedge clk_i);
            #StimDelay;
        end
        exists_req_i = 1'b0;

        // The push wins the shared lookup, and the pop goes through a cycle later
        test_name = "push_priority";
        drain_all();
        push_elem(id_t'(1), data_t'($urandom));
        inp_req_i  = 1'b1;
        inp_id_i   = id_t'(1);
        inp_data_i = data_t'($urandom);
        oup_req_i  = 1'b1;
        oup_id_i   = id_t'(1);
        oup_pop_i  = 1'b1;
        @(negedge clk_i);
        check("oup_gnt_o during push", 32'd0, 32'(oup_gnt_o));
        check("inp_gnt_o during push", 32'd1, 32'(inp_gnt_o));
        @(posedge clk_i);
        #StimDelay;
        inp_req_i = 1'b0;
        wait_grant(1'b1, "output grant after push");
        @(posedge clk_i);
        #StimDelay;
        oup_req_i = 1'b0;
        oup_pop_i = 1'b0;

        // Emptying an ID retires its chain, and the next push opens a new one
        test_name = "chain_restart";
        drain_all();
        push_elem(id_t'(3), data_t'($urandom));
        push_elem(id_t'(3), data_t'($urandom));
        access_elem(id_t'(3), 1'b1);
        access_elem(id_t'(3), 1'b1);
        access_elem(id_t'(3), 1'b0);
        push_elem(id_t'(3), data_t'($urandom));
        access_elem(id_t'(3), 1'b0);
        access_elem(id_t'(3), 1'b1);
        access_elem(id_t'(3), 1'b0);

        finish_run();
    end

endmodule

// File: rtl/id_queue_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the ID queue
// Push and pop controllers around the head-tail and data tables
// Input, output and exists ports plus full and empty status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module id_queue_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      inp_req_i,
    input  id_queue_types_pkg::id_t   inp_id_i,
    input  id_queue_types_pkg::data_t inp_data_i,
    output logic                      inp_gnt_o,
    input  logic                      oup_req_i,
    input  id_queue_types_pkg::id_t   oup_id_i,
    input  logic                      oup_pop_i,
    output logic                      oup_gnt_o,
    output logic                      oup_data_valid_o,
    output id_queue_types_pkg::data_t oup_data_o,
    input  logic                      exists_req_i,
    input  id_queue_types_pkg::data_t exists_data_i,
    input  id_queue_types_pkg::data_t exists_mask_i,
    output logic                      exists_gnt_o,
    output logic                      exists_o,
    output logic                      full_o,
    output logic                      empty_o
);

    import id_queue_types_pkg::*;

    // Lookup results and table read data
    logic    push;
    logic    id_hit;
    ld_idx_t hit_head;
    ld_idx_t hit_tail;
    ld_idx_t ld_free_idx;
    data_t   head_data;
    ld_idx_t head_next;

    // Update strobes applied by the tables at the next edge
    logic ht_alloc;
    logic ht_append;
    logic ld_write;
    logic ht_release;
    logic ht_advance;
    logic ld_release;

    id_queue_push u_push (
        .inp_req_i   (inp_req_i),
        .full_i      (full_o),
        .id_hit_i    (id_hit),
        .inp_gnt_o   (inp_gnt_o),
        .push_o      (push),
        .ht_alloc_o  (ht_alloc),
        .ht_append_o (ht_append),
        .ld_write_o  (ld_write)
    );

    head_tail_store u_head_tail (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .push_i        (push),
        .inp_id_i      (inp_id_i),
        .oup_id_i      (oup_id_i),
        .ld_free_idx_i (ld_free_idx),
        .head_next_i   (head_next),
        .ht_alloc_i    (ht_alloc),
        .ht_append_i   (ht_append),
        .ht_release_i  (ht_release),
        .ht_advance_i  (ht_advance),
        .id_hit_o      (id_hit),
        .hit_head_o    (hit_head),
        .hit_tail_o    (hit_tail)
    );

    linked_data_store u_linked_data (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .inp_data_i    (inp_data_i),
        .hit_head_i    (hit_head),
        .hit_tail_i    (hit_tail),
        .ld_write_i    (ld_write),
        .ht_append_i   (ht_append),
        .ld_release_i  (ld_release),
        .exists_data_i (exists_data_i),
        .exists_mask_i (exists_mask_i),
        .exists_req_i  (exists_req_i),
        .full_o        (full_o),
        .empty_o       (empty_o),
        .ld_free_idx_o (ld_free_idx),
        .head_data_o   (head_data),
        .head_next_o   (head_next),
        .exists_o      (exists_o),
        .exists_gnt_o  (exists_gnt_o)
    );

    id_queue_pop u_pop (
        .oup_req_i        (oup_req_i),
        .oup_pop_i        (oup_pop_i),
        .push_i           (push),
        .id_hit_i         (id_hit),
        .hit_head_i       (hit_head),
        .hit_tail_i       (hit_tail),
        .head_data_i      (head_data),
        .oup_gnt_o        (oup_gnt_o),
        .oup_data_valid_o (oup_data_valid_o),
        .oup_data_o       (oup_data_o),
        .ht_release_o     (ht_release),
        .ht_advance_o     (ht_advance),
        .ld_release_o     (ld_release)
    );

endmodule

// File: rtl/id_queue_pop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pop controller of the ID queue
// Output grant, peek data of the oldest element per ID
// Cell release and head-tail release or advance on a pop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module id_queue_pop (
    input  logic                        oup_req_i,
    input  logic                        oup_pop_i,
    input  logic                        push_i,
    input  logic                        id_hit_i,
    input  id_queue_types_pkg::ld_idx_t hit_head_i,
    input  id_queue_types_pkg::ld_idx_t hit_tail_i,
    input  id_queue_types_pkg::data_t   head_data_i,
    output logic                        oup_gnt_o,
    output logic                        oup_data_valid_o,
    output id_queue_types_pkg::data_t   oup_data_o,
    output logic                        ht_release_o,
    output logic                        ht_advance_o,
    output logic                        ld_release_o
);

    logic pop_taken;
    logic last_elem;

    // A push in the same cycle owns the matcher, so the output must wait
    assign oup_gnt_o = oup_req_i && !push_i;

    // A granted access to an ID without elements still completes but carries no data
    assign oup_data_valid_o = oup_gnt_o && id_hit_i;
    assign oup_data_o       = oup_data_valid_o ? head_data_i : '0;

    // Only a destructive access on a valid element changes state
    assign pop_taken = oup_data_valid_o && oup_pop_i;

    // Head equal to tail means the chain holds a single element
    assign last_elem = (hit_head_i == hit_tail_i);

    // The head cell always goes back to the free pool
    assign ld_release_o = pop_taken;

    // The entry either disappears with its last element or moves its head along the link
    assign ht_release_o = pop_taken && last_elem;
    assign ht_advance_o = pop_taken && !last_elem;

endmodule

// File: rtl/id_queue_push.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Push controller of the ID queue
// Input grant from the full flag
// Choice between a new chain and an append to an existing one
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module id_queue_push (
    input  logic inp_req_i,
    input  logic full_i,
    input  logic id_hit_i,
    output logic inp_gnt_o,
    output logic push_o,
    output logic ht_alloc_o,
    output logic ht_append_o,
    output logic ld_write_o
);

    // The input side is granted whenever a cell is free
    // There is no dependence on the output side since the push has priority
    assign inp_gnt_o = !full_i;

    // A push is a completed handshake on the input port
    assign push_o = inp_req_i && inp_gnt_o;

    // During a push the shared matcher looks at the input ID, so the hit
    // tells whether that ID already owns a chain
    always_comb begin
        ht_alloc_o  = 1'b0;
        ht_append_o = 1'b0;
        if (push_o) begin
            if (id_hit_i) begin
                // Link behind the current tail of the chain
                ht_append_o = 1'b1;
            end else begin
                // First element of this ID opens a new head-tail entry
                ht_alloc_o = 1'b1;
            end
        end
    end

    // Every push fills exactly one cell no matter which chain it joins
    assign ld_write_o = push_o;

endmodule

// File: rtl/linked_data_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Linked data table of the ID queue
// Element cells with payload, next link and free flag
// Free-cell search, full and empty status
// Masked exists search over all occupied cells
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module linked_data_store (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  id_queue_types_pkg::data_t   inp_data_i,
    input  id_queue_types_pkg::ld_idx_t hit_head_i,
    input  id_queue_types_pkg::ld_idx_t hit_tail_i,
    input  logic                        ld_write_i,
    input  logic                        ht_append_i,
    input  logic                        ld_release_i,
    input  id_queue_types_pkg::data_t   exists_data_i,
    input  id_queue_types_pkg::data_t   exists_mask_i,
    input  logic                        exists_req_i,
    output logic                        full_o,
    output logic                        empty_o,
    output id_queue_types_pkg::ld_idx_t ld_free_idx_o,
    output id_queue_types_pkg::data_t   head_data_o,
    output id_queue_types_pkg::ld_idx_t head_next_o,
    output logic                        exists_o,
    output logic                        exists_gnt_o
);

    import id_queue_cfg_pkg::*;
    import id_queue_types_pkg::*;

    linked_data_t ld_q [Capacity];

    logic [Capacity-1:0] ld_free;
    logic [Capacity-1:0] exists_match;
    logic                ld_any_free;

    // Gather the free flags and compare every occupied cell against the masked query
    always_comb begin
        for (int i = 0; i < Capacity; i++) begin
            ld_free[i]      = ld_q[i].free;
            exists_match[i] = !ld_q[i].free &&
                              ((ld_q[i].data & exists_mask_i) == (exists_data_i & exists_mask_i));
        end
    end

    first_free_index #(
        .WIDTH (Capacity)
    ) u_ld_free (
        .free_i (ld_free),
        .idx_o  (ld_free_idx_o),
        .any_o  (ld_any_free)
    );

    // Full means no cell is left to take a push
    assign full_o  = !ld_any_free;
    assign empty_o = &ld_free;

    // The head cell of the looked-up chain feeds the output and the head advance
    assign head_data_o = ld_q[hit_head_i].data;
    assign head_next_o = ld_q[hit_head_i].next;

    // The exists port is always ready
    assign exists_gnt_o = exists_req_i;
    assign exists_o     = exists_req_i && (|exists_match);

    // Reset returns every cell to the free pool
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < Capacity; i++) begin
                ld_q[i].free <= 1'b1;
            end
        end else begin
            if (ld_write_i) begin
                ld_q[ld_free_idx_o] <= '{data: inp_data_i, next: '0, free: 1'b0};
            end
            // The old tail now points at the new cell
            if (ht_append_i) begin
                ld_q[hit_tail_i].next <= ld_free_idx_o;
            end
            if (ld_release_i) begin
                ld_q[hit_head_i].free <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/head_tail_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Head-tail table of the ID queue
// One entry per live ID with the head and tail cell of its chain
// Single ID lookup, free-entry search and entry updates
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module head_tail_store (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        push_i,
    input  id_queue_types_pkg::id_t     inp_id_i,
    input  id_queue_types_pkg::id_t     oup_id_i,
    input  id_queue_types_pkg::ld_idx_t ld_free_idx_i,
    input  id_queue_types_pkg::ld_idx_t head_next_i,
    input  logic                        ht_alloc_i,
    input  logic                        ht_append_i,
    input  logic                        ht_release_i,
    input  logic                        ht_advance_i,
    output logic                        id_hit_o,
    output id_queue_types_pkg::ld_idx_t hit_head_o,
    output id_queue_types_pkg::ld_idx_t hit_tail_o
);

    import id_queue_cfg_pkg::*;
    import id_queue_types_pkg::*;

    head_tail_t ht_q [HtCapacity];

    id_t                   lookup_id;
    logic [HtCapacity-1:0] id_match;
    logic [HtCapacity-1:0] ht_free;
    ht_idx_t               hit_idx;
    ht_idx_t               ht_free_idx;
    logic                  ht_any_free;

    // There is only one matcher, and a push takes it away from the output side
    assign lookup_id = push_i ? inp_id_i : oup_id_i;

    // An entry matches only while it is occupied
    always_comb begin
        for (int i = 0; i < HtCapacity; i++) begin
            id_match[i] = !ht_q[i].free && (ht_q[i].id == lookup_id);
            ht_free[i]  = ht_q[i].free;
        end
    end

    // At most one entry holds a given ID, so OR-ing the indices gives the binary hit index
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < HtCapacity; i++) begin
            if (id_match[i]) begin
                hit_idx = hit_idx | ht_idx_t'(i);
            end
        end
    end

    first_free_index #(
        .WIDTH (HtCapacity)
    ) u_ht_free (
        .free_i (ht_free),
        .idx_o  (ht_free_idx),
        .any_o  (ht_any_free)
    );

    assign id_hit_o   = |id_match;
    assign hit_head_o = ht_q[hit_idx].head;
    assign hit_tail_o = ht_q[hit_idx].tail;

    // Push strobes and pop strobes never arrive in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < HtCapacity; i++) begin
                ht_q[i] <= '{free: 1'b1, default: '0};
            end
        end else begin
            // A new chain starts with a single cell that is both head and tail
            if (ht_alloc_i && ht_any_free) begin
                ht_q[ht_free_idx] <= '{
                    id:   inp_id_i,
                    head: ld_free_idx_i,
                    tail: ld_free_idx_i,
                    free: 1'b0
                };
            end
            // The freshly written cell becomes the new tail of the chain
            if (ht_append_i) begin
                ht_q[hit_idx].tail <= ld_free_idx_i;
            end
            // Popping the only cell of a chain retires the whole entry
            if (ht_release_i) begin
                ht_q[hit_idx] <= '{free: 1'b1, default: '0};
            end
            // Otherwise the head follows the link of the popped cell
            if (ht_advance_i) begin
                ht_q[hit_idx].head <= head_next_i;
            end
        end
    end

endmodule

// File: rtl/first_free_index.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Priority encoder for free-slot search
// Returns the lowest set bit of a vector and an any-set flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module first_free_index #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         free_i,
    output logic [$clog2(WIDTH)-1:0] idx_o,
    output logic                     any_o
);

    localparam int IdxWidth = $clog2(WIDTH);

    // Walk from the top down so that the lowest set bit is the last one written
    always_comb begin
        idx_o = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (free_i[i]) begin
                idx_o = IdxWidth'(i);
            end
        end
    end

    // When nothing is set the index is zero and must be ignored
    assign any_o = |free_i;

endmodule

// File: rtl/id_queue_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data types of the ID queue
// ID, payload and index types
// Head-tail table entry and linked data cell structures
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package id_queue_types_pkg;

    // Element ID as seen on the input and output ports
    typedef logic [id_queue_cfg_pkg::IdWidth-1:0] id_t;

    // Payload stored with every element
    typedef logic [id_queue_cfg_pkg::DataWidth-1:0] data_t;

    // Index into the linked data table
    typedef logic [id_queue_cfg_pkg::LdIdxWidth-1:0] ld_idx_t;

    // Index into the head-tail table
    typedef logic [id_queue_cfg_pkg::HtIdxWidth-1:0] ht_idx_t;

    // One chain descriptor
    // Head points at the oldest cell of the ID and tail at the youngest one
    typedef struct packed {
        id_t     id;
        ld_idx_t head;
        ld_idx_t tail;
        logic    free;
    } head_tail_t;

    // One element cell
    // The next field is only meaningful when the cell is not the tail of its chain
    typedef struct packed {
        data_t   data;
        ld_idx_t next;
        logic    free;
    } linked_data_t;

endpackage

// File: rtl/id_queue_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Size constants of the ID queue
// Widths of IDs, payloads and table indices
// Element and head-tail table capacities
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package id_queue_cfg_pkg;

    // Each element carries an ID of this many bits
    localparam int IdWidth = 2;

    // Number of element cells in the linked data table
    localparam int Capacity = 8;

    // Every ID value can own at most one chain
    localparam int NumIds = 2 ** IdWidth;

    // A chain needs at least one cell, so more chains than cells is pointless
    localparam int HtCapacity = (NumIds <= Capacity) ? NumIds : Capacity;

    localparam int LdIdxWidth = $clog2(Capacity);
    localparam int HtIdxWidth = $clog2(HtCapacity);

    // Width of one stored payload word
    localparam int DataWidth = 16;

endpackage
